//--- list.f
+incdir+include
design/membus_pkg.sv
design/memoryIo.sv
design/wordRam.sv
design/hexDisplay.sv
design/uartRegs.sv
design/uartTxFsm.sv
design/baudTimer.sv
design/memSystem.sv
verif/tbMemSystem.sv

//--- run.sh
#!/bin/sh
# build and run the memory bus testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbMemSystem -f list.f -o simMemSystem
./obj_dir/simMemSystem

//--- verif/tbMemSystem.sv
// testbench for the memory bus system covering RAM lanes, display, UART registers and frames
`timescale 1ns/1ns
`include "membus_consts.svh"

module tbMemSystem import membus_pkg::*; ();

    localparam int CLK_NS = 20;
    localparam int TESTS = 6;
    localparam int FRAME_NS = 10 * `BAUD_DIV * CLK_NS;
    localparam int TIMEOUT_NS = TESTS * FRAME_NS + 20000;
    localparam busAddrT LSR_ADDR = `UART_BASE + `UART_LSR;
    localparam busAddrT THR_ADDR = `UART_BASE + `UART_THR;
    // common-cathode gfedcba patterns for 0 through F
    localparam logic [6:0] SEG [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D,
        7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    logic clk;
    logic rst;
    busReqT req;
    wordT rdata;
    logic txd;
    logic [27:0] hexSegs;
    wordT shadow [`RAM_WORDS];
    busAddrT written [$];
    int seed = 32'h7598ed4a;

    memSystem dut (.clk(clk), .rst(rst), .req(req), .rdata(rdata), .txd(txd), .hexSegs(hexSegs));

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic failCheck(input string name, input logic [27:0] expected,
                             input logic [27:0] actual);
        $display("error %s: expected %h, actual %h", name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    // line must be idle once a reset cycle is over
    assert property (@(posedge clk) rst |=> txd)
        else failCheck("reset txd", 28'd1, {27'd0, txd});

    // starts at a falling edge and returns at the next one with we low
    task automatic busWrite(input busAddrT addr, input wordT data, input logic be);
        req.addr = addr;
        req.wdata = data;
        req.be = be;
        req.we = 1'b1;
        @(negedge clk);
        req.we = 1'b0;
    endtask

    task automatic busRead(input busAddrT addr, input logic be, output wordT data);
        req.we = 1'b0;
        req.addr = addr;
        req.be = be;
        #1;
        data = rdata;
        @(negedge clk);
    endtask

    task automatic checkRead(input string name, input busAddrT addr, input logic be,
                             input wordT expected);
        wordT got;
        busRead(addr, be, got);
        assert (got == expected) else failCheck(name, {12'd0, expected}, {12'd0, got});
    endtask

    // sample each bit in its middle counted from the start edge
    task automatic recvFrame(input string name, input byteT expected);
        logic [9:0] frame;
        @(negedge txd);
        repeat (`BAUD_DIV / 2) @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            frame[i] = txd;
            if (i < 9) repeat (`BAUD_DIV) @(negedge clk);
        end
        assert (frame == {1'b1, expected, 1'b0})
            else failCheck(name, {18'd0, 1'b1, expected, 1'b0}, {18'd0, frame});
    endtask

    initial begin
        int r;
        busAddrT addr;
        wordT data;
        wordT lsr;
        byteT first;
        byteT second;
        rst = 1'b1;
        req = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // display value starts at zero
        assert (hexSegs == {4{SEG[0]}})
            else failCheck("display after reset", {4{SEG[0]}}, hexSegs);

        // UART registers
        checkRead("reset line status", LSR_ADDR, 1'b0, 16'h0060);
        checkRead("scratch after reset", `UART_BASE + `UART_SCR, 1'b0, 16'h0000);
        busWrite(`UART_BASE + `UART_SCR, 16'h77A5, 1'b0);
        checkRead("scratch", `UART_BASE + `UART_SCR, 1'b0, 16'h00A5);
        for (int off = 0; off < 7; off++) begin
            if (off != `UART_LSR) checkRead("unused offset", `UART_BASE + 16'(off), 1'b0, '0);
        end

        // random halfwords where upper RAM addresses alias onto the low index bits
        for (int n = 0; n < 16; n++) begin
            r = $random(seed);
            addr = {r[15:1], 1'b0};
            if (addr >= `HEX_BASE) addr = addr - 16'h0100;
            busWrite(addr, r[31:16], 1'b0);
            shadow[addr[10:1]] = r[31:16];
            written.push_back(addr);
            checkRead("word", addr, 1'b0, shadow[addr[10:1]]);
        end
        foreach (written[i]) checkRead("word reread", written[i], 1'b0, shadow[written[i][10:1]]);

        // byte lanes with the odd address as the low byte
        r = $random(seed);
        addr = {5'd0, r[10:1], 1'b0};
        busWrite(addr, 16'h1234, 1'b0);
        shadow[addr[10:1]] = 16'h1234;
        busWrite(addr | 16'd1, r[31:16], 1'b1);
        shadow[addr[10:1]][7:0] = r[23:16];
        checkRead("byte low lane", addr, 1'b0, shadow[addr[10:1]]);
        busWrite(addr, {r[7:0], r[31:24]}, 1'b1);
        shadow[addr[10:1]][15:8] = r[31:24];
        checkRead("byte high lane", addr, 1'b0, shadow[addr[10:1]]);
        checkRead("byte read odd", addr | 16'd1, 1'b1, {8'h00, shadow[addr[10:1]][7:0]});
        checkRead("byte read even", addr, 1'b1, {8'h00, shadow[addr[10:1]][15:8]});

        // display
        r = $random(seed);
        data = r[15:0];
        busWrite(`HEX_BASE + 16'd2, data, 1'b0);
        assert (hexSegs == {SEG[data[15:12]], SEG[data[11:8]], SEG[data[7:4]], SEG[data[3:0]]})
            else failCheck("display segments",
                {SEG[data[15:12]], SEG[data[11:8]], SEG[data[7:4]], SEG[data[3:0]]}, hexSegs);
        checkRead("display read", `HEX_BASE + 16'd4, 1'b0, 16'hCAFE);

        // single frame
        r = $random(seed);
        first = r[7:0];
        second = r[15:8];
        busWrite(THR_ADDR, {8'h00, first}, 1'b0);
        recvFrame("single frame", first);
        repeat (`BAUD_DIV) @(negedge clk);
        checkRead("line status after frame", LSR_ADDR, 1'b0, 16'h0060);

        // back-to-back frames with the second byte written once the holding register empties
        fork
            begin
                recvFrame("first frame", second);
                recvFrame("second frame", first);
            end
            begin
                busWrite(THR_ADDR, {8'h00, second}, 1'b0);
                do begin
                    busRead(LSR_ADDR, 1'b0, lsr);
                end while (!lsr[5]);
                busWrite(THR_ADDR, {8'h00, first}, 1'b0);
                // holding register is full again so this byte is lost
                busWrite(THR_ADDR, {8'h00, ~first}, 1'b0);
            end
        join
        repeat (`BAUD_DIV) @(negedge clk);
        checkRead("line status after pair", LSR_ADDR, 1'b0, 16'h0060);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- design/memSystem.sv
// top level: bus controller with RAM, display and transmit-only UART
`timescale 1ns/1ns

module memSystem import membus_pkg::*; (
    input logic clk,
    input logic rst,
    input busReqT req,
    output wordT rdata,
    output logic txd,
    output logic [27:0] hexSegs
);

    ramReqT ramReq;
    wordT ramRdata;
    logic hexWe;
    wordT hexData;
    devWrT uartWr;
    byteT uartRdata;
    logic thrFull;
    byteT thrData;
    logic txReady;
    logic txBusy;
    logic timerStart;
    logic timerEn;
    logic bitTick;

    memoryIo uCtrl (
        .req(req),
        .ramRdata(ramRdata),
        .uartRdata(uartRdata),
        .ramReq(ramReq),
        .hexWe(hexWe),
        .hexData(hexData),
        .uartWr(uartWr),
        .rdata(rdata)
    );

    wordRam uRam (
        .clk(clk),
        .ramReq(ramReq),
        .rdata(ramRdata)
    );

    hexDisplay uHex (
        .clk(clk),
        .rst(rst),
        .hexWe(hexWe),
        .hexData(hexData),
        .hexSegs(hexSegs)
    );

    uartRegs uRegs (
        .clk(clk),
        .rst(rst),
        .uartWr(uartWr),
        .txReady(txReady),
        .txBusy(txBusy),
        .thrFull(thrFull),
        .thrData(thrData),
        .uartRdata(uartRdata)
    );

    uartTxFsm uTx (
        .clk(clk),
        .rst(rst),
        .thrFull(thrFull),
        .bitTick(bitTick),
        .thrData(thrData),
        .txReady(txReady),
        .txBusy(txBusy),
        .timerStart(timerStart),
        .timerEn(timerEn),
        .txd(txd)
    );

    baudTimer uBaud (
        .clk(clk),
        .rst(rst),
        .timerStart(timerStart),
        .timerEn(timerEn),
        .bitTick(bitTick)
    );

endmodule

//--- design/baudTimer.sv
// bit-period timer, pulses bitTick at the end of every serial bit
`timescale 1ns/1ns
`include "membus_consts.svh"

module baudTimer (
    input logic clk,
    input logic rst,
    input logic timerStart,
    input logic timerEn,
    output logic bitTick
);

    localparam int CW = $clog2(`BAUD_DIV + 1);
    localparam logic [CW-1:0] RELOAD = CW'(`BAUD_DIV - 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (timerStart) begin
            count <= RELOAD;
        end else if (timerEn) begin
            // wrap straight back so consecutive bits stay exact
            count <= (count == '0) ? RELOAD : count - 1'b1;
        end
    end

    assign bitTick = timerEn && (count == '0);

endmodule

//--- design/uartTxFsm.sv
// UART transmit FSM, shifts 8N1 frames out on txd
`timescale 1ns/1ns

module uartTxFsm import membus_pkg::*; (
    input logic clk,
    input logic rst,
    input logic thrFull,
    input logic bitTick,
    input byteT thrData,
    output logic txReady,
    output logic txBusy,
    output logic timerStart,
    output logic timerEn,
    output logic txd
);

    txStateT state;
    byteT shiftReg;
    logic [2:0] bitCnt;

    assign txReady = (state == txIdle);
    assign txBusy = (state != txIdle);
    // take the byte and start the bit timer together
    assign timerStart = txReady && thrFull;
    assign timerEn = txBusy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= txIdle;
            bitCnt <= '0;
        end else begin
            case (state)
                txIdle: if (thrFull) state <= txStart;
                txStart: begin
                    if (bitTick) begin
                        state <= txData;
                        bitCnt <= '0;
                    end
                end
                txData: begin
                    if (bitTick) begin
                        bitCnt <= bitCnt + 3'd1;
                        if (bitCnt == 3'd7) state <= txStop;
                    end
                end
                default: if (bitTick) state <= txIdle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (timerStart) begin
            shiftReg <= thrData;
        end else if (state == txData && bitTick) begin
            shiftReg <= {1'b0, shiftReg[7:1]};
        end
    end

    assign txd = (state == txStart) ? 1'b0 : (state == txData) ? shiftReg[0] : 1'b1;

endmodule

//--- design/uartRegs.sv
// UART register file: holding, scratch and line status registers
`timescale 1ns/1ns
`include "membus_consts.svh"

module uartRegs import membus_pkg::*; (
    input logic clk,
    input logic rst,
    input devWrT uartWr,
    input logic txReady,
    input logic txBusy,
    output logic thrFull,
    output byteT thrData,
    output byteT uartRdata
);

    byteT scratch;
    byteT lsr;
    logic thrWrite;
    logic scrWrite;

    // a write while the holding register is full is lost
    assign thrWrite = uartWr.we && (uartWr.addr == `UART_THR) && !thrFull;
    assign scrWrite = uartWr.we && (uartWr.addr == `UART_SCR);

    always_ff @(posedge clk) begin
        if (rst) begin
            thrFull <= 1'b0;
            scratch <= '0;
        end else begin
            // handoff to the transmitter empties the holding register
            if (thrFull && txReady) begin
                thrFull <= 1'b0;
            end else if (thrWrite) begin
                thrFull <= 1'b1;
            end
            if (scrWrite) begin
                scratch <= uartWr.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (thrWrite) begin
            thrData <= uartWr.data;
        end
    end

    // bit 5 holding register empty, bit 6 transmitter empty
    assign lsr = {1'b0, !(thrFull || txBusy), !thrFull, 5'b0};

    always_comb begin
        case (uartWr.addr)
            `UART_LSR: uartRdata = lsr;
            `UART_SCR: uartRdata = scratch;
            default: uartRdata = '0;
        endcase
    end

endmodule

//--- design/hexDisplay.sv
// display register with four parallel hex to seven-segment decoders
`timescale 1ns/1ns

module hexDisplay import membus_pkg::*; (
    input logic clk,
    input logic rst,
    input logic hexWe,
    input wordT hexData,
    output logic [27:0] hexSegs
);

    wordT hexValue;

    // gfedcba, active high
    function automatic logic [6:0] segOf(input logic [3:0] nib);
        case (nib)
            4'h0: segOf = 7'h3F;
            4'h1: segOf = 7'h06;
            4'h2: segOf = 7'h5B;
            4'h3: segOf = 7'h4F;
            4'h4: segOf = 7'h66;
            4'h5: segOf = 7'h6D;
            4'h6: segOf = 7'h7D;
            4'h7: segOf = 7'h07;
            4'h8: segOf = 7'h7F;
            4'h9: segOf = 7'h6F;
            4'hA: segOf = 7'h77;
            4'hB: segOf = 7'h7C;
            4'hC: segOf = 7'h39;
            4'hD: segOf = 7'h5E;
            4'hE: segOf = 7'h79;
            default: segOf = 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            hexValue <= '0;
        end else if (hexWe) begin
            hexValue <= hexData;
        end
    end

    // digit 3 ends up in the top group
    for (genvar d = 0; d < 4; d++) begin : gDigit
        assign hexSegs[d*7 +: 7] = segOf(hexValue[d*4 +: 4]);
    end

endmodule

//--- design/wordRam.sv
// halfword RAM with per-lane write enables and asynchronous read
`timescale 1ns/1ns
`include "membus_consts.svh"

module wordRam import membus_pkg::*; (
    input logic clk,
    input ramReqT ramReq,
    output wordT rdata
);

    localparam int AW = $clog2(`RAM_WORDS);

    wordT mem [`RAM_WORDS];
    logic [AW-1:0] idx;

    // only the low index bits are kept, so the top of the map aliases
    assign idx = ramReq.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (ramReq.we) begin
            for (int i = 0; i < 2; i++) begin
                if (ramReq.lanes[i]) begin
                    mem[idx][i*8 +: 8] <= ramReq.wdata[i*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[idx];

endmodule

//--- design/memoryIo.sv
// bus controller: address decode, byte-lane steering and read-data selection
`timescale 1ns/1ns
`include "membus_consts.svh"

module memoryIo import membus_pkg::*; (
    input busReqT req,
    input wordT ramRdata,
    input byteT uartRdata,
    output ramReqT ramReq,
    output logic hexWe,
    output wordT hexData,
    output devWrT uartWr,
    output wordT rdata
);

    logic isRam;
    logic isHex;
    logic isUart;
    logic lowLane;
    byteT ramByte;

    // region decode
    assign isRam = req.addr < `HEX_BASE;
    assign isUart = req.addr >= `UART_BASE;
    assign isHex = !isRam && !isUart;

    // odd address picks the low byte
    assign lowLane = req.addr[0];

    // byte address to halfword index
    assign ramReq.addr = req.addr[15:1];
    assign ramReq.we = req.we && isRam;

    always_comb begin
        ramReq.wdata = req.wdata;
        ramReq.lanes = 2'b11;
        if (req.be) begin
            if (lowLane) begin
                ramReq.wdata = {8'h00, req.wdata[7:0]};
                ramReq.lanes = 2'b01;
            end else begin
                ramReq.wdata = {req.wdata[7:0], 8'h00};
                ramReq.lanes = 2'b10;
            end
        end
    end

    assign hexWe = req.we && isHex;
    assign hexData = req.wdata;

    // UART sees only the low address bits and the low data byte
    assign uartWr.addr = req.addr[2:0];
    assign uartWr.data = req.wdata[7:0];
    assign uartWr.we = req.we && isUart;

    assign ramByte = lowLane ? ramRdata[7:0] : ramRdata[15:8];

    always_comb begin
        if (isRam) begin
            if (req.be) begin
                rdata = {8'h00, ramByte};
            end else begin
                rdata = ramRdata;
            end
        end else if (isUart) begin
            rdata = {8'h00, uartRdata};
        end else begin
            // display has no read side, return a marker
            rdata = 16'hCAFE;
        end
    end

endmodule

//--- design/membus_pkg.sv
// memory bus types: data vectors, request structs and transmitter states
package membus_pkg;

    typedef logic [15:0] wordT;
    typedef logic [7:0] byteT;
    typedef logic [15:0] busAddrT;
    typedef logic [14:0] ramAddrT;
    typedef logic [2:0] regAddrT;
    // bit 1 is the high byte
    typedef logic [1:0] laneT;

    // processor strobe bus, be flags a byte access
    typedef struct packed {
        busAddrT addr;
        wordT wdata;
        logic we;
        logic be;
    } busReqT;

    typedef struct packed {
        ramAddrT addr;
        wordT wdata;
        laneT lanes;
        logic we;
    } ramReqT;

    typedef struct packed {
        regAddrT addr;
        byteT data;
        logic we;
    } devWrT;

    typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txStateT;

endpackage

//--- include/membus_consts.svh
// memory bus constants: address map, UART register offsets and serial bit timing
`ifndef MEMBUS_CONSTS_SVH
`define MEMBUS_CONSTS_SVH

// address map
// 0x0000 - 0xff7f  word RAM
// 0xff80 - 0xff8f  seven-segment display
// 0xff90 - 0xff9f  16450-style UART
`define HEX_BASE 16'hFF80
`define UART_BASE 16'hFF90

// UART register offsets within its range
`define UART_THR 3'd0
`define UART_LSR 3'd5
`define UART_SCR 3'd7

// clocks per serial bit
`define BAUD_DIV 8

// RAM depth in halfwords, upper addresses alias
`define RAM_WORDS 1024

`endif
